/* src/fpu_ss_params.svh */
// Size and width macros for the floating-point offload subsystem
// Cores, register file, memory metadata queue and bus widths

`ifndef FPU_SS_PARAMS_SVH
`define FPU_SS_PARAMS_SVH

// --------------------
// Cores
// --------------------
`define FPU_SS_NB_CORES 4
`define FPU_SS_CORE_W 2

// --------------------
// Register file
// --------------------
`define FPU_SS_NUM_FPR 32
`define FPU_SS_REG_ADDR_W 5

// --------------------
// Bus widths and queue
// --------------------
`define FPU_SS_XLEN 32
`define FPU_SS_ID_W 4

// Up to three memory ops in flight per core
`define FPU_SS_MEM_FIFO_DEPTH 3

`endif

/* src/fpu_ss_instr_pkg.sv */
// RISC-V encoding constants for the offloaded float instructions
// and the instruction word union with its I-type and S-type views

package fpu_ss_instr_pkg;

  // Major opcodes
  localparam logic [6:0] OPC_LOAD_FP = 7'b000_0111;
  localparam logic [6:0] OPC_STORE_FP = 7'b010_0111;
  localparam logic [6:0] OPC_OP_FP = 7'b101_0011;

  // funct7 of the two register moves
  localparam logic [6:0] FUNCT7_FMV_X_W = 7'b111_0000;
  localparam logic [6:0] FUNCT7_FMV_W_X = 7'b111_1000;

  // Word access width for flw and fsw
  localparam logic [2:0] FUNCT3_W = 3'b010;
  // Both moves carry funct3 zero
  localparam logic [2:0] FUNCT3_FMV = 3'b000;

  // --------------------
  // Instruction views
  // --------------------
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } itype_t;

  // Store offset split around rs2 and rs1
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } stype_t;

  typedef union packed {
    itype_t i;
    stype_t s;
  } instr_u;

endpackage

/* src/fpu_ss_pkg.sv */
// Subsystem types: operation kind from the decoder
// and the per-core memory metadata entry

package fpu_ss_pkg;

`include "fpu_ss_params.svh"

  // --------------------
  // Operation kind
  // --------------------
  typedef enum logic [2:0] {
    OP_NONE      = 3'd0,
    OP_LOAD      = 3'd1,
    OP_STORE     = 3'd2,
    OP_MV_TO_FP  = 3'd3,
    OP_MV_TO_INT = 3'd4
  } op_kind_e;

  // --------------------
  // Memory metadata
  // --------------------
  // One entry per outstanding memory op, we set for a load
  typedef struct packed {
    logic [`FPU_SS_REG_ADDR_W-1:0] rd;
    logic [`FPU_SS_ID_W-1:0]       id;
    logic                          we;
  } mem_meta_t;

endpackage

/* src/fpu_ss_decoder.sv */
// Combinational decoder for flw, fsw, fmv.w.x and fmv.x.w
`timescale 1ns/1ps

`include "fpu_ss_params.svh"

module fpu_ss_decoder (
  input  fpu_ss_instr_pkg::instr_u        instr_i,
  output fpu_ss_pkg::op_kind_e            op_kind_o,
  output logic [`FPU_SS_REG_ADDR_W-1:0]   rd_o,
  output logic [`FPU_SS_REG_ADDR_W-1:0]   rs1_o,
  output logic [`FPU_SS_REG_ADDR_W-1:0]   rs2_o,
  output logic [`FPU_SS_XLEN-1:0]         offset_o,
  output logic [2:0]                      size_o
);

  logic is_mv_fmt;

  // Moves need funct3 zero and rs2 zero
  assign is_mv_fmt = (instr_i.s.funct3 == fpu_ss_instr_pkg::FUNCT3_FMV) &&
                     (instr_i.s.rs2 == '0);

  // --------------------
  // Operation match
  // --------------------
  always_comb begin
    op_kind_o = fpu_ss_pkg::OP_NONE;
    unique case (instr_i.i.opcode)
      fpu_ss_instr_pkg::OPC_LOAD_FP: begin
        if (instr_i.i.funct3 == fpu_ss_instr_pkg::FUNCT3_W) begin
          op_kind_o = fpu_ss_pkg::OP_LOAD;
        end
      end
      fpu_ss_instr_pkg::OPC_STORE_FP: begin
        if (instr_i.s.funct3 == fpu_ss_instr_pkg::FUNCT3_W) begin
          op_kind_o = fpu_ss_pkg::OP_STORE;
        end
      end
      fpu_ss_instr_pkg::OPC_OP_FP: begin
        if (is_mv_fmt && instr_i.s.imm_hi == fpu_ss_instr_pkg::FUNCT7_FMV_W_X) begin
          op_kind_o = fpu_ss_pkg::OP_MV_TO_FP;
        end else if (is_mv_fmt && instr_i.s.imm_hi == fpu_ss_instr_pkg::FUNCT7_FMV_X_W) begin
          op_kind_o = fpu_ss_pkg::OP_MV_TO_INT;
        end
      end
      default: begin
        op_kind_o = fpu_ss_pkg::OP_NONE;
      end
    endcase
  end

  // Register fields sit at the same bits in both views
  assign rd_o = instr_i.i.rd;
  assign rs1_o = instr_i.i.rs1;
  assign rs2_o = instr_i.s.rs2;
  assign size_o = instr_i.i.funct3;

  // Stores split the offset, everything else takes the I-type immediate
  always_comb begin
    if (instr_i.s.opcode == fpu_ss_instr_pkg::OPC_STORE_FP) begin
      offset_o = {{(`FPU_SS_XLEN-12){instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
    end else begin
      offset_o = {{(`FPU_SS_XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
    end
  end

endmodule

/* src/fpu_ss_regfile.sv */
// Float register file of one core, two read ports and one write port
`timescale 1ns/1ps

`include "fpu_ss_params.svh"

module fpu_ss_regfile (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic [`FPU_SS_REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`FPU_SS_REG_ADDR_W-1:0] raddr_b_i,
  output logic [`FPU_SS_XLEN-1:0]       rdata_a_o,
  output logic [`FPU_SS_XLEN-1:0]       rdata_b_o,
  input  logic [`FPU_SS_REG_ADDR_W-1:0] waddr_i,
  input  logic [`FPU_SS_XLEN-1:0]       wdata_i,
  input  logic                          we_i
);

  logic [`FPU_SS_XLEN-1:0] regs_q [`FPU_SS_NUM_FPR];

  // --------------------
  // Write port
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int r = 0; r < `FPU_SS_NUM_FPR; r++) begin
        regs_q[r] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // --------------------
  // Read ports
  // --------------------
  // No bypass, a write is seen from the next cycle on
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

/* src/fpu_ss_mem_fifo.sv */
// In-order queue of outstanding memory metadata for one core
`timescale 1ns/1ps

`include "fpu_ss_params.svh"

module fpu_ss_mem_fifo #(
  parameter int DEPTH = `FPU_SS_MEM_FIFO_DEPTH
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  push_i,
  input  fpu_ss_pkg::mem_meta_t push_data_i,
  output logic                  full_o,
  input  logic                  pop_i,
  output fpu_ss_pkg::mem_meta_t pop_data_o,
  output logic                  empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  fpu_ss_pkg::mem_meta_t entries_q [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      count_q;

  assign full_o = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign pop_data_o = entries_q[rd_ptr_q];

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      entries_q[wr_ptr_q] <= push_data_i;
    end
  end

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Memory results only answer requests that were queued
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o);

  // Issue must stall the core before its queue overflows
  a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_o);

endmodule

/* src/fpu_ss_controller.sv */
// Issue acceptance, memory request strobes, result register
// and the choice between memory and move writeback
`timescale 1ns/1ps

`include "fpu_ss_params.svh"

module fpu_ss_controller (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          x_issue_valid_i,
  input  fpu_ss_pkg::op_kind_e          op_kind_i,
  input  logic                          core_full_i,
  input  logic                          x_mem_ready_i,
  input  logic                          x_mem_result_valid_i,
  output logic                          x_issue_ready_o,
  output logic                          x_issue_accept_o,
  output logic                          x_issue_writeback_o,
  output logic                          x_issue_loadstore_o,
  output logic                          x_mem_valid_o,
  output logic                          x_mem_we_o,
  output logic                          push_o,
  output logic                          pop_o,
  output logic                          fpr_we_o,
  output logic                          wb_from_mem_o,
  input  logic [`FPU_SS_ID_W-1:0]       issue_id_i,
  input  logic [`FPU_SS_CORE_W-1:0]     issue_core_i,
  input  logic [`FPU_SS_REG_ADDR_W-1:0] rd_i,
  input  logic [`FPU_SS_XLEN-1:0]       fpr_rdata_i,
  input  logic                          x_result_ready_i,
  output logic                          x_result_valid_o,
  output logic [`FPU_SS_XLEN-1:0]       x_result_data_o,
  output logic [`FPU_SS_REG_ADDR_W-1:0] x_result_rd_o,
  output logic [`FPU_SS_ID_W-1:0]       x_result_id_o,
  output logic [`FPU_SS_CORE_W-1:0]     dest_core_id_o
);

  logic is_mem;
  logic issue_fire;

  assign is_mem = (op_kind_i == fpu_ss_pkg::OP_LOAD) || (op_kind_i == fpu_ss_pkg::OP_STORE);

  // Issue response depends on the word alone
  assign x_issue_accept_o = (op_kind_i != fpu_ss_pkg::OP_NONE);
  assign x_issue_writeback_o = (op_kind_i == fpu_ss_pkg::OP_MV_TO_INT);
  assign x_issue_loadstore_o = is_mem;

  // --------------------
  // Issue ready
  // --------------------
  always_comb begin
    x_issue_ready_o = !x_result_valid_o;
    if (is_mem && (!x_mem_ready_i || core_full_i)) begin
      x_issue_ready_o = 1'b0;
    end
    // Register file write port is taken by the memory result
    if (op_kind_i == fpu_ss_pkg::OP_MV_TO_FP && x_mem_result_valid_i) begin
      x_issue_ready_o = 1'b0;
    end
  end

  assign issue_fire = x_issue_valid_i && x_issue_ready_o;

  // Memory request goes out in the issue cycle
  assign x_mem_valid_o = issue_fire && is_mem;
  assign x_mem_we_o = (op_kind_i == fpu_ss_pkg::OP_STORE);
  assign push_o = x_mem_valid_o;
  assign pop_o = x_mem_result_valid_i;

  // Memory result wins the write port, a move never collides with it
  assign wb_from_mem_o = x_mem_result_valid_i;
  assign fpr_we_o = x_mem_result_valid_i || (issue_fire && op_kind_i == fpu_ss_pkg::OP_MV_TO_FP);

  // --------------------
  // Result register
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      x_result_valid_o <= 1'b0;
    end else if (issue_fire && op_kind_i == fpu_ss_pkg::OP_MV_TO_INT) begin
      x_result_valid_o <= 1'b1;
    end else if (x_result_ready_i) begin
      x_result_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_fire && op_kind_i == fpu_ss_pkg::OP_MV_TO_INT) begin
      x_result_data_o <= fpr_rdata_i;
      x_result_rd_o <= rd_i;
      x_result_id_o <= issue_id_i;
      dest_core_id_o <= issue_core_i;
    end
  end

  // Result holds under back-pressure
  a_result_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    x_result_valid_o && !x_result_ready_i |=> x_result_valid_o && $stable(x_result_data_o) &&
      $stable(x_result_rd_o) && $stable(x_result_id_o) && $stable(dest_core_id_o));

endmodule

/* src/fpu_ss.sv */
// Top level of the shared float register offload subsystem
// Decoder, controller, per-core register files and memory queues
`timescale 1ns/1ps

`include "fpu_ss_params.svh"

module fpu_ss (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // Issue port
  input  logic                          x_issue_valid_i,
  input  fpu_ss_instr_pkg::instr_u      x_issue_instr_i,
  input  logic [`FPU_SS_XLEN-1:0]       x_issue_rs1_i,
  input  logic [`FPU_SS_ID_W-1:0]       x_issue_id_i,
  input  logic [`FPU_SS_CORE_W-1:0]     core_id_i,
  output logic                          x_issue_ready_o,
  output logic                          x_issue_accept_o,
  output logic                          x_issue_writeback_o,
  output logic                          x_issue_loadstore_o,
  // Memory request port
  output logic                          x_mem_valid_o,
  input  logic                          x_mem_ready_i,
  output logic [`FPU_SS_XLEN-1:0]       x_mem_addr_o,
  output logic                          x_mem_we_o,
  output logic [`FPU_SS_XLEN-1:0]       x_mem_wdata_o,
  output logic [2:0]                    x_mem_size_o,
  output logic [`FPU_SS_ID_W-1:0]       x_mem_id_o,
  output logic [`FPU_SS_CORE_W-1:0]     mem_dest_core_id_o,
  // Memory result port
  input  logic                          x_mem_result_valid_i,
  input  logic [`FPU_SS_XLEN-1:0]       x_mem_result_rdata_i,
  input  logic [`FPU_SS_CORE_W-1:0]     mem_result_core_id_i,
  // Result port
  output logic                          x_result_valid_o,
  input  logic                          x_result_ready_i,
  output logic [`FPU_SS_XLEN-1:0]       x_result_data_o,
  output logic [`FPU_SS_REG_ADDR_W-1:0] x_result_rd_o,
  output logic [`FPU_SS_ID_W-1:0]       x_result_id_o,
  output logic [`FPU_SS_CORE_W-1:0]     dest_core_id_o
);

  fpu_ss_pkg::op_kind_e          op_kind;
  logic [`FPU_SS_REG_ADDR_W-1:0] rd;
  logic [`FPU_SS_REG_ADDR_W-1:0] rs1;
  logic [`FPU_SS_REG_ADDR_W-1:0] rs2;
  logic [`FPU_SS_XLEN-1:0]       offset;
  logic                          push;
  logic                          pop;
  logic                          fpr_we;
  logic                          wb_from_mem;
  logic                          mem_wb_ok;
  logic [`FPU_SS_CORE_W-1:0]     wb_core;
  logic [`FPU_SS_REG_ADDR_W-1:0] fpr_waddr;
  logic [`FPU_SS_XLEN-1:0]       fpr_wdata;
  logic [`FPU_SS_XLEN-1:0]       rdata_a [`FPU_SS_NB_CORES];
  logic [`FPU_SS_XLEN-1:0]       rdata_b [`FPU_SS_NB_CORES];
  logic [`FPU_SS_NB_CORES-1:0]   fifo_full;
  logic [`FPU_SS_NB_CORES-1:0]   fifo_empty;
  fpu_ss_pkg::mem_meta_t         push_meta;
  fpu_ss_pkg::mem_meta_t         pop_meta [`FPU_SS_NB_CORES];

  fpu_ss_decoder fpu_ss_decoder_i (
    .instr_i   (x_issue_instr_i),
    .op_kind_o (op_kind),
    .rd_o      (rd),
    .rs1_o     (rs1),
    .rs2_o     (rs2),
    .offset_o  (offset),
    .size_o    (x_mem_size_o)
  );

  fpu_ss_controller fpu_ss_controller_i (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .x_issue_valid_i      (x_issue_valid_i),
    .op_kind_i            (op_kind),
    .core_full_i          (fifo_full[core_id_i]),
    .x_mem_ready_i        (x_mem_ready_i),
    .x_mem_result_valid_i (x_mem_result_valid_i),
    .x_issue_ready_o      (x_issue_ready_o),
    .x_issue_accept_o     (x_issue_accept_o),
    .x_issue_writeback_o  (x_issue_writeback_o),
    .x_issue_loadstore_o  (x_issue_loadstore_o),
    .x_mem_valid_o        (x_mem_valid_o),
    .x_mem_we_o           (x_mem_we_o),
    .push_o               (push),
    .pop_o                (pop),
    .fpr_we_o             (fpr_we),
    .wb_from_mem_o        (wb_from_mem),
    .issue_id_i           (x_issue_id_i),
    .issue_core_i         (core_id_i),
    .rd_i                 (rd),
    .fpr_rdata_i          (rdata_a[core_id_i]),
    .x_result_ready_i     (x_result_ready_i),
    .x_result_valid_o     (x_result_valid_o),
    .x_result_data_o      (x_result_data_o),
    .x_result_rd_o        (x_result_rd_o),
    .x_result_id_o        (x_result_id_o),
    .dest_core_id_o       (dest_core_id_o)
  );

  // --------------------
  // Memory request
  // --------------------
  assign x_mem_addr_o = x_issue_rs1_i + offset;
  assign x_mem_wdata_o = (op_kind == fpu_ss_pkg::OP_STORE) ? rdata_b[core_id_i] : '0;
  assign x_mem_id_o = x_issue_id_i;
  assign mem_dest_core_id_o = core_id_i;

  assign push_meta.rd = rd;
  assign push_meta.id = x_issue_id_i;
  assign push_meta.we = (op_kind == fpu_ss_pkg::OP_LOAD);

  // --------------------
  // Writeback steering
  // --------------------
  // Stores pop their entry without touching the register file
  assign mem_wb_ok = !fifo_empty[mem_result_core_id_i] && pop_meta[mem_result_core_id_i].we;
  assign wb_core = wb_from_mem ? mem_result_core_id_i : core_id_i;
  assign fpr_waddr = wb_from_mem ? pop_meta[mem_result_core_id_i].rd : rd;
  assign fpr_wdata = wb_from_mem ? x_mem_result_rdata_i : x_issue_rs1_i;

  for (genvar c = 0; c < `FPU_SS_NB_CORES; c++) begin : gen_core
    logic core_we;

    assign core_we = fpr_we && (wb_core == `FPU_SS_CORE_W'(c)) && (!wb_from_mem || mem_wb_ok);

    fpu_ss_regfile fpu_ss_regfile_i (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .raddr_a_i (rs1),
      .raddr_b_i (rs2),
      .rdata_a_o (rdata_a[c]),
      .rdata_b_o (rdata_b[c]),
      .waddr_i   (fpr_waddr),
      .wdata_i   (fpr_wdata),
      .we_i      (core_we)
    );

    fpu_ss_mem_fifo fpu_ss_mem_fifo_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .push_i      (push && (core_id_i == `FPU_SS_CORE_W'(c))),
      .push_data_i (push_meta),
      .full_o      (fifo_full[c]),
      .pop_i       (pop && (mem_result_core_id_i == `FPU_SS_CORE_W'(c))),
      .pop_data_o  (pop_meta[c]),
      .empty_o     (fifo_empty[c])
    );
  end

endmodule

/* testbench/fpu_ss_clk_gen.sv */
// Clock and reset generator for the offload subsystem testbench
`timescale 1ns/1ps

module fpu_ss_clk_gen #(
  parameter int PERIOD_NS  = 4,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    // Release on a falling edge, away from the sampling edge
    @(negedge clk_o);
    rst_o = 1'b0;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

/* testbench/fpu_ss_tb.sv */
// Testbench for fpu_ss with random stimulus and a memory responder
// Reference model of all register files and per-cycle checks
`timescale 1ns/1ps

`include "fpu_ss_params.svh"

module fpu_ss_tb;

  localparam int NB = `FPU_SS_NB_CORES;
  localparam int DEPTH = `FPU_SS_MEM_FIFO_DEPTH;
  localparam int TIMEOUT = 300;
  localparam int K_NONE = 0;
  localparam int K_LOAD = 1;
  localparam int K_STORE = 2;
  localparam int K_MV_TO_FP = 3;
  localparam int K_MV_TO_INT = 4;

  logic clk, rst;
  logic x_issue_valid_i, x_issue_ready_o, x_issue_accept_o;
  logic x_issue_writeback_o, x_issue_loadstore_o;
  fpu_ss_instr_pkg::instr_u x_issue_instr_i;
  logic [31:0] x_issue_rs1_i;
  logic [3:0] x_issue_id_i;
  logic [1:0] core_id_i;
  logic x_mem_valid_o, x_mem_ready_i, x_mem_we_o;
  logic [31:0] x_mem_addr_o, x_mem_wdata_o;
  logic [2:0] x_mem_size_o;
  logic [3:0] x_mem_id_o;
  logic [1:0] mem_dest_core_id_o;
  logic x_mem_result_valid_i;
  logic [31:0] x_mem_result_rdata_i;
  logic [1:0] mem_result_core_id_i;
  logic x_result_valid_o, x_result_ready_i;
  logic [31:0] x_result_data_o;
  logic [4:0] x_result_rd_o;
  logic [3:0] x_result_id_o;
  logic [1:0] dest_core_id_o;

  // --------------------
  // Reference model state
  // --------------------
  logic [31:0] model_fpr [NB][`FPU_SS_NUM_FPR];
  logic [31:0] mem_model [logic [31:0]];
  int          pend_cnt [NB];
  logic        pend_load [NB][DEPTH];
  logic [4:0]  pend_rd [NB][DEPTH];
  logic [31:0] pend_data [NB][DEPTH];
  logic        res_valid;
  logic [31:0] res_data;
  logic [4:0]  res_rd;
  logic [3:0]  res_id;
  logic [1:0]  res_core;
  logic        resp_enable, mem_stall;
  logic [3:0]  next_id;
  int          err_cnt, check_cnt, timeout_cnt;

  fpu_ss_clk_gen clk_gen_i (.clk_o(clk), .rst_o(rst));

  fpu_ss dut_i (
    .clk_i(clk), .rst_i(rst),
    .x_issue_valid_i(x_issue_valid_i), .x_issue_instr_i(x_issue_instr_i),
    .x_issue_rs1_i(x_issue_rs1_i), .x_issue_id_i(x_issue_id_i), .core_id_i(core_id_i),
    .x_issue_ready_o(x_issue_ready_o), .x_issue_accept_o(x_issue_accept_o),
    .x_issue_writeback_o(x_issue_writeback_o), .x_issue_loadstore_o(x_issue_loadstore_o),
    .x_mem_valid_o(x_mem_valid_o), .x_mem_ready_i(x_mem_ready_i),
    .x_mem_addr_o(x_mem_addr_o), .x_mem_we_o(x_mem_we_o), .x_mem_wdata_o(x_mem_wdata_o),
    .x_mem_size_o(x_mem_size_o), .x_mem_id_o(x_mem_id_o),
    .mem_dest_core_id_o(mem_dest_core_id_o),
    .x_mem_result_valid_i(x_mem_result_valid_i), .x_mem_result_rdata_i(x_mem_result_rdata_i),
    .mem_result_core_id_i(mem_result_core_id_i),
    .x_result_valid_o(x_result_valid_o), .x_result_ready_i(x_result_ready_i),
    .x_result_data_o(x_result_data_o), .x_result_rd_o(x_result_rd_o),
    .x_result_id_o(x_result_id_o), .dest_core_id_o(dest_core_id_o)
  );

  // --------------------
  // Encoding helpers
  // --------------------
  function automatic logic [31:0] enc_flw(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'h07};
  endfunction

  function automatic logic [31:0] enc_fsw(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h27};
  endfunction

  function automatic logic [31:0] enc_fmv_w_x(input logic [4:0] rd, input logic [4:0] rs1);
    return {7'h78, 5'd0, rs1, 3'b000, rd, 7'h53};
  endfunction

  function automatic logic [31:0] enc_fmv_x_w(input logic [4:0] rd, input logic [4:0] rs1);
    return {7'h70, 5'd0, rs1, 3'b000, rd, 7'h53};
  endfunction

  // Operation kind straight from the ISA encoding
  function automatic int decode_kind(input logic [31:0] w);
    if (w[6:0] == 7'h07 && w[14:12] == 3'b010) return K_LOAD;
    if (w[6:0] == 7'h27 && w[14:12] == 3'b010) return K_STORE;
    if (w[6:0] == 7'h53 && w[14:12] == 3'b000 && w[24:20] == 5'd0) begin
      if (w[31:25] == 7'h78) return K_MV_TO_FP;
      if (w[31:25] == 7'h70) return K_MV_TO_INT;
    end
    return K_NONE;
  endfunction

  function automatic logic [31:0] word_offset(input logic [31:0] w, input int kind);
    if (kind == K_STORE) return {{20{w[31]}}, w[31:25], w[11:7]};
    return {{20{w[31]}}, w[31:20]};
  endfunction

  // Untouched memory reads a pattern of the full address
  function automatic logic [31:0] mem_read(input logic [31:0] a);
    if (mem_model.exists(a)) return mem_model[a];
    return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic logic [31:0] rand_base();
    return 32'h0000_2000 + 32'(($urandom % 64) << 2);
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  // --------------------
  // One clock cycle
  // --------------------
  task automatic step(input logic valid, input logic [31:0] word, input logic [31:0] rs1v,
                      input logic [3:0] id, input logic [1:0] core, output logic fired);
    int kind, rc, c0, k;
    logic rv, exp_ready, is_mem;
    logic [31:0] rdat, addr, exp_wdata, rd_val;
    logic [4:0] rd;
    kind = valid ? decode_kind(word) : K_NONE;
    is_mem = (kind == K_LOAD) || (kind == K_STORE);
    rd = word[11:7];
    addr = rs1v + word_offset(word, kind);
    rv = 1'b0;
    rc = 0;
    rdat = $urandom;
    // Responder answers the oldest op of one busy core
    if (resp_enable && ($urandom % 3) == 0) begin
      c0 = int'($urandom % NB);
      for (k = 0; k < NB; k++) begin
        if (!rv && pend_cnt[(c0 + k) % NB] > 0) begin
          rv = 1'b1;
          rc = (c0 + k) % NB;
        end
      end
      if (rv && pend_load[rc][0]) rdat = pend_data[rc][0];
    end
    @(negedge clk);
    x_issue_valid_i = valid;
    x_issue_instr_i = word;
    x_issue_rs1_i = rs1v;
    x_issue_id_i = id;
    core_id_i = core;
    x_mem_result_valid_i = rv;
    drive_mem_result(rc, rdat);
    x_mem_ready_i = mem_stall ? 1'b0 : (($urandom % 4) != 0);
    x_result_ready_i = 1'($urandom);
    #1;
    exp_ready = !res_valid;
    if (is_mem && (!x_mem_ready_i || pend_cnt[core] == DEPTH)) exp_ready = 1'b0;
    if (kind == K_MV_TO_FP && rv) exp_ready = 1'b0;
    exp_wdata = (kind == K_STORE) ? model_fpr[core][word[24:20]] : 32'h0;
    rd_val = model_fpr[core][word[19:15]];
    fired = valid && exp_ready;
    if (valid) begin
      compare("x_issue_accept_o", 32'(x_issue_accept_o), 32'(kind != K_NONE));
      compare("x_issue_writeback_o", 32'(x_issue_writeback_o), 32'(kind == K_MV_TO_INT));
      compare("x_issue_loadstore_o", 32'(x_issue_loadstore_o), 32'(is_mem));
      compare("x_issue_ready_o", 32'(x_issue_ready_o), 32'(exp_ready));
    end
    compare("x_mem_valid_o", 32'(x_mem_valid_o), 32'(fired && is_mem));
    if (fired && is_mem) begin
      compare("x_mem_addr_o", x_mem_addr_o, addr);
      compare("x_mem_we_o", 32'(x_mem_we_o), 32'(kind == K_STORE));
      compare("x_mem_size_o", 32'(x_mem_size_o), 32'h2);
      compare("x_mem_id_o", 32'(x_mem_id_o), 32'(id));
      compare("mem_dest_core_id_o", 32'(mem_dest_core_id_o), 32'(core));
      compare("x_mem_wdata_o", x_mem_wdata_o, exp_wdata);
    end
    compare("x_result_valid_o", 32'(x_result_valid_o), 32'(res_valid));
    if (res_valid) begin
      compare("x_result_data_o", x_result_data_o, res_data);
      compare("x_result_rd_o", 32'(x_result_rd_o), 32'(res_rd));
      compare("x_result_id_o", 32'(x_result_id_o), 32'(res_id));
      compare("dest_core_id_o", 32'(dest_core_id_o), 32'(res_core));
    end
    // Model update for the coming rising edge
    if (rv) begin
      if (pend_load[rc][0]) model_fpr[rc][pend_rd[rc][0]] = pend_data[rc][0];
      for (k = 0; k < DEPTH - 1; k++) begin
        pend_load[rc][k] = pend_load[rc][k + 1];
        pend_rd[rc][k] = pend_rd[rc][k + 1];
        pend_data[rc][k] = pend_data[rc][k + 1];
      end
      pend_cnt[rc]--;
    end
    if (res_valid && x_result_ready_i) res_valid = 1'b0;
    if (fired) begin
      if (is_mem) begin
        pend_load[core][pend_cnt[core]] = (kind == K_LOAD);
        pend_rd[core][pend_cnt[core]] = rd;
        pend_data[core][pend_cnt[core]] = mem_read(addr);
        pend_cnt[core]++;
      end
      case (kind)
        K_STORE: mem_model[addr] = exp_wdata;
        K_MV_TO_FP: model_fpr[core][rd] = rs1v;
        K_MV_TO_INT: begin
          res_valid = 1'b1;
          res_data = rd_val;
          res_rd = rd;
          res_id = id;
          res_core = core;
        end
        default: ;
      endcase
    end
  endtask

  task automatic drive_mem_result(input int rc, input logic [31:0] rdat);
    mem_result_core_id_i = 2'(rc);
    x_mem_result_rdata_i = rdat;
  endtask

  // Holds valid until the word transfers
  task automatic issue(input logic [31:0] word, input logic [31:0] rs1v, input logic [1:0] core);
    int waited;
    logic fired;
    fired = 1'b0;
    waited = 0;
    while (!fired && waited < TIMEOUT) begin
      step(1'b1, word, rs1v, next_id, core, fired);
      waited++;
    end
    if (!fired) begin
      timeout_cnt++;
      $display("Timeout: word %08h on core %0d was not accepted in %0d cycles",
               word, core, TIMEOUT);
    end
    next_id = next_id + 4'd1;
  endtask

  task automatic drain();
    int waited;
    int busy;
    logic fired;
    waited = 0;
    busy = 1;
    while (busy != 0 && waited < TIMEOUT) begin
      busy = res_valid ? 1 : 0;
      for (int c = 0; c < NB; c++) busy += pend_cnt[c];
      if (busy != 0) step(1'b0, 32'h0, 32'h0, 4'h0, 2'd0, fired);
      waited++;
    end
    if (busy != 0) begin
      timeout_cnt++;
      $display("Timeout: memory results or the pending result never drained");
    end
  endtask

  task automatic random_op(input logic [1:0] core);
    int sel;
    logic [4:0] ra, rb;
    logic [11:0] imm;
    sel = int'($urandom % 4);
    ra = 5'($urandom);
    rb = 5'($urandom);
    imm = 12'((($urandom % 32) << 2) - 64);
    case (sel)
      0: issue(enc_flw(ra, rb, imm), rand_base(), core);
      1: issue(enc_fsw(ra, rb, imm), rand_base(), core);
      2: issue(enc_fmv_w_x(ra, rb), $urandom, core);
      default: issue(enc_fmv_x_w(ra, rb), 32'h0, core);
    endcase
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    int n;
    logic [31:0] w;
    logic [4:0] r;
    logic [1:0] cr;
    logic fired;
    void'($urandom(32'hc583_4ebf));
    x_issue_valid_i = 1'b0;
    x_issue_instr_i = '0;
    x_issue_rs1_i = '0;
    x_issue_id_i = '0;
    core_id_i = '0;
    x_mem_ready_i = 1'b1;
    x_mem_result_valid_i = 1'b0;
    x_mem_result_rdata_i = '0;
    mem_result_core_id_i = '0;
    x_result_ready_i = 1'b0;
    for (int c = 0; c < NB; c++) begin
      pend_cnt[c] = 0;
      for (int i = 0; i < `FPU_SS_NUM_FPR; i++) model_fpr[c][i] = '0;
    end
    res_valid = 1'b0;
    resp_enable = 1'b1;
    mem_stall = 1'b0;
    next_id = '0;
    err_cnt = 0;
    check_cnt = 0;
    timeout_cnt = 0;

    n = 0;
    while (rst !== 1'b0 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      timeout_cnt++;
      $display("Timeout: reset was never released");
    end

    // Random words with many near misses of the four encodings
    for (n = 0; n < 150; n++) begin
      w = $urandom;
      case ($urandom % 4)
        0: w[6:0] = 7'h53;
        1: w[6:0] = (($urandom % 2) == 0) ? 7'h07 : 7'h27;
        default: ;
      endcase
      issue(w, $urandom, 2'($urandom));
    end
    drain();

    // Move pairs read back under random result stalls
    for (n = 0; n < 40; n++) begin
      r = 5'($urandom);
      cr = 2'($urandom);
      issue(enc_fmv_w_x(r, 5'($urandom)), $urandom, cr);
      issue(enc_fmv_x_w(5'($urandom), r), 32'h0, cr);
    end

    // Mixed loads, stores and moves across cores
    for (n = 0; n < 250; n++) random_op(2'($urandom));
    drain();

    // Memory not ready
    mem_stall = 1'b1;
    w = enc_flw(5'd3, 5'd1, 12'h010);
    for (n = 0; n < 6; n++) step(1'b1, w, 32'h2100, next_id, 2'd0, fired);
    mem_stall = 1'b0;
    issue(w, 32'h2100, 2'd0);
    drain();

    // Core 1 queue full while other cores keep going
    resp_enable = 1'b0;
    for (n = 0; n < DEPTH; n++) issue(enc_flw(5'(n + 4), 5'd2, 12'(n * 4)), 32'h2200, 2'd1);
    w = enc_fsw(5'd4, 5'd2, 12'hff0);
    for (n = 0; n < 6; n++) step(1'b1, w, 32'h2300, next_id, 2'd1, fired);
    issue(enc_flw(5'd9, 5'd2, 12'h008), 32'h2200, 2'd2);
    resp_enable = 1'b1;
    issue(w, 32'h2300, 2'd1);
    drain();

    // Full register file read back on every core
    for (int c = 0; c < NB; c++) begin
      for (int i = 0; i < `FPU_SS_NUM_FPR; i++) issue(enc_fmv_x_w(5'(i), 5'(i)), 32'h0, 2'(c));
    end
    drain();

    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* fpu_ss.f */
+incdir+src
src/fpu_ss_instr_pkg.sv
src/fpu_ss_pkg.sv
src/fpu_ss_decoder.sv
src/fpu_ss_regfile.sv
src/fpu_ss_mem_fifo.sv
src/fpu_ss_controller.sv
src/fpu_ss.sv
testbench/fpu_ss_clk_gen.sv
testbench/fpu_ss_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the fpu_ss testbench with Verilator, run it, and pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module fpu_ss_tb \
  -f fpu_ss.f -o fpu_ss_sim || { echo "Build failed"; exit 1; }

out=$(./obj_dir/fpu_ss_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED" && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
